// File: verilog/gpif_pkg.sv
package gpif_pkg;

   // Line and bus widths
   localparam int LINE_W = 18;
   localparam int WORD_W = 16;
   localparam int EOP_BIT = 17;
   localparam int SOP_BIT = 16;

   localparam int READ_COUNT_W = 9;
   localparam int PKT_COUNT_W = 8;
   localparam int LEVEL_W = 16;
   localparam int DEBUG_W = 32;

   // Burst caps per endpoint
   localparam int DATA_BURST_LINES = 256;
   localparam int RESP_BURST_LINES = 16;

   // Response flag clears at a full burst
   localparam int RESP_READY_LEVEL = 16;

   // Buffer depths as log2 of entries
   localparam int CDC_DEPTH_LOG2 = 4;
   localparam int PKT_DEPTH_LOG2 = 9;

   // System line, eop and sop above the payload
   typedef logic [LINE_W-1:0] gpif_line_t;

   typedef logic [WORD_W-1:0] gpif_word_t;

   typedef logic [READ_COUNT_W-1:0] read_count_t;

   typedef logic [PKT_COUNT_W-1:0] pkt_count_t;

   typedef logic [LEVEL_W-1:0] fifo_level_t;

   typedef logic [DEBUG_W-1:0] debug_word_t;

endpackage

// File: verilog/fifo_2clock.sv
`timescale 1ns/10ps

module fifo_2clock
   import gpif_pkg::*;
   #(parameter int WIDTH = LINE_W,
     parameter int DEPTH_LOG2 = CDC_DEPTH_LOG2)
   (input  logic             wclk,
    input  logic             arst_i,
    input  logic             rclk,
    input  logic [WIDTH-1:0] data_i,
    input  logic             src_rdy_i,
    output logic             dst_rdy_o,
    output logic [WIDTH-1:0] data_o,
    output logic             src_rdy_o,
    input  logic             dst_rdy_i,
    output fifo_level_t      occupied_o);

   // One extra pointer bit tells full from empty
   typedef logic [DEPTH_LOG2:0] ptr_t;

   logic [WIDTH-1:0] mem [2**DEPTH_LOG2];

   ptr_t wr_bin;
   ptr_t wr_gray;
   ptr_t wr_bin_next;
   ptr_t wr_gray_next;
   ptr_t wq1_rgray;
   ptr_t wq2_rgray;
   logic wr_full;
   logic wr_full_next;
   logic wr_en;

   ptr_t rd_bin;
   ptr_t rd_gray;
   ptr_t rd_bin_next;
   ptr_t rd_gray_next;
   ptr_t rq1_wgray;
   ptr_t rq2_wgray;
   ptr_t rd_fill;
   logic rd_empty;
   logic rd_empty_next;
   logic rd_en;
   fifo_level_t level_q;

   function automatic ptr_t bin2gray(input ptr_t b);
      return b ^ (b >> 1);
   endfunction

   function automatic ptr_t gray2bin(input ptr_t g);
      ptr_t b;
      b[DEPTH_LOG2] = g[DEPTH_LOG2];
      for (int i = DEPTH_LOG2 - 1; i >= 0; i--)
         b[i] = b[i+1] ^ g[i];
      return b;
   endfunction

   // Write domain
   assign wr_en = src_rdy_i & dst_rdy_o;
   assign wr_bin_next = wr_bin + ptr_t'(wr_en);
   assign wr_gray_next = bin2gray(wr_bin_next);
   // Full when the top two Gray bits differ and the rest match
   assign wr_full_next = (wr_gray_next ==
                          {~wq2_rgray[DEPTH_LOG2 -: 2], wq2_rgray[DEPTH_LOG2-2:0]});

   always_ff @(posedge wclk) begin
      if (wr_en)
         mem[wr_bin[DEPTH_LOG2-1:0]] <= data_i;
   end

   // Full held high in reset so the writer sees no space
   always_ff @(posedge wclk or posedge arst_i) begin
      if (arst_i) begin
         wr_bin <= '0;
         wr_gray <= '0;
         wr_full <= 1'b1;
         wq1_rgray <= '0;
         wq2_rgray <= '0;
      end else begin
         wr_bin <= wr_bin_next;
         wr_gray <= wr_gray_next;
         wr_full <= wr_full_next;
         wq1_rgray <= rd_gray;
         wq2_rgray <= wq1_rgray;
      end
   end

   assign dst_rdy_o = ~wr_full;

   // Read domain
   assign rd_en = src_rdy_o & dst_rdy_i;
   assign rd_bin_next = rd_bin + ptr_t'(rd_en);
   assign rd_gray_next = bin2gray(rd_bin_next);
   assign rd_empty_next = (rd_gray_next == rq2_wgray);
   assign rd_fill = gray2bin(rq2_wgray) - rd_bin_next;

   always_ff @(posedge rclk or posedge arst_i) begin
      if (arst_i) begin
         rd_bin <= '0;
         rd_gray <= '0;
         rd_empty <= 1'b1;
         rq1_wgray <= '0;
         rq2_wgray <= '0;
         level_q <= '0;
      end else begin
         rd_bin <= rd_bin_next;
         rd_gray <= rd_gray_next;
         rd_empty <= rd_empty_next;
         rq1_wgray <= wr_gray;
         rq2_wgray <= rq1_wgray;
         level_q <= fifo_level_t'(rd_fill);
      end
   end

   // Show-ahead head
   assign data_o = mem[rd_bin[DEPTH_LOG2-1:0]];
   assign src_rdy_o = ~rd_empty;
   assign occupied_o = level_q;

endmodule

// File: verilog/fifo_sync.sv
`timescale 1ns/10ps

module fifo_sync
   #(parameter int WIDTH = 18,
     parameter int DEPTH_LOG2 = 4)
   (input  logic             clk,
    input  logic             rst_i,
    input  logic             clear_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             src_rdy_i,
    output logic             dst_rdy_o,
    output logic [WIDTH-1:0] data_o,
    output logic             src_rdy_o,
    input  logic             dst_rdy_i);

   logic [WIDTH-1:0] mem [2**DEPTH_LOG2];

   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic                  push;
   logic                  pop;

   assign push = src_rdy_i & dst_rdy_o;
   assign pop = src_rdy_o & dst_rdy_i;

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= data_i;
   end

   always_ff @(posedge clk) begin
      if (rst_i || clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         // Simultaneous push and pop leaves the count alone
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   // Count only reaches the top bit when completely full
   assign dst_rdy_o = ~count[DEPTH_LOG2];
   assign src_rdy_o = |count;
   assign data_o = mem[rd_ptr];

endmodule

// File: verilog/gpif_rd.sv
`timescale 1ns/10ps

module gpif_rd
   import gpif_pkg::*;
   (input  logic        gpif_clk,
    input  logic        gpif_rst_i,
    output gpif_word_t  gpif_data_o,
    input  logic        gpif_rd_i,
    input  logic        gpif_ep_i,
    output logic        gpif_empty_d_o,
    output logic        gpif_empty_c_o,

    input  logic        sys_clk,
    input  logic        sys_rst_i,
    input  gpif_line_t  data_i,
    input  logic        src_rdy_i,
    output logic        dst_rdy_o,
    input  gpif_line_t  resp_i,
    input  logic        resp_src_rdy_i,
    output logic        resp_dst_rdy_o,
    output debug_word_t debug_o);

   logic gpif_clk_n;

   read_count_t read_count;
   pkt_count_t  pkt_count;

   gpif_line_t  cdc_line;
   logic        cdc_src_rdy;
   logic        pkt_dst_rdy;
   gpif_line_t  pkt_line;
   logic        pkt_src_rdy;
   gpif_line_t  resp_line;
   logic        resp_src_rdy;
   fifo_level_t resp_level;

   logic        send_data_line;
   logic        send_resp_line;
   logic        pkt_in_eop;
   logic        pkt_out_sop;

   // FIFO read sides follow the GPIF falling edge
   assign gpif_clk_n = ~gpif_clk;

   // Strobes per burst, cleared whenever the strobe drops
   always_ff @(negedge gpif_clk) begin
      if (gpif_rst_i || !gpif_rd_i)
         read_count <= '0;
      else if (read_count != '1)
         read_count <= read_count + 1'b1;
   end

   assign send_data_line = gpif_rd_i & ~gpif_ep_i &
                           (read_count < read_count_t'(DATA_BURST_LINES));
   assign send_resp_line = gpif_rd_i & gpif_ep_i &
                           (read_count < read_count_t'(RESP_BURST_LINES));

   // Data path
   fifo_2clock #(.WIDTH(LINE_W), .DEPTH_LOG2(CDC_DEPTH_LOG2)) data_cdc_fifo (
      .wclk       (sys_clk),
      .arst_i     (sys_rst_i),
      .rclk       (gpif_clk_n),
      .data_i     (data_i),
      .src_rdy_i  (src_rdy_i),
      .dst_rdy_o  (dst_rdy_o),
      .data_o     (cdc_line),
      .src_rdy_o  (cdc_src_rdy),
      .dst_rdy_i  (pkt_dst_rdy),
      .occupied_o ());

   fifo_sync #(.WIDTH(LINE_W), .DEPTH_LOG2(PKT_DEPTH_LOG2)) pkt_fifo (
      .clk       (gpif_clk_n),
      .rst_i     (gpif_rst_i),
      .clear_i   (1'b0),
      .data_i    (cdc_line),
      .src_rdy_i (cdc_src_rdy),
      .dst_rdy_o (pkt_dst_rdy),
      .data_o    (pkt_line),
      .src_rdy_o (pkt_src_rdy),
      .dst_rdy_i (send_data_line));

   // Whole packets: counted in at eop, out at sop
   assign pkt_in_eop = cdc_src_rdy & pkt_dst_rdy & cdc_line[EOP_BIT];
   assign pkt_out_sop = pkt_src_rdy & send_data_line & pkt_line[SOP_BIT];

   always_ff @(negedge gpif_clk) begin
      if (gpif_rst_i)
         pkt_count <= '0;
      else if (pkt_in_eop && !pkt_out_sop)
         pkt_count <= pkt_count + 1'b1;
      else if (pkt_out_sop && !pkt_in_eop)
         pkt_count <= pkt_count - 1'b1;
   end

   always_ff @(negedge gpif_clk) begin
      if (gpif_rst_i)
         gpif_empty_d_o <= 1'b1;
      else
         gpif_empty_d_o <= (pkt_count == '0);
   end

   // Response path
   fifo_2clock #(.WIDTH(LINE_W), .DEPTH_LOG2(CDC_DEPTH_LOG2)) resp_cdc_fifo (
      .wclk       (sys_clk),
      .arst_i     (sys_rst_i),
      .rclk       (gpif_clk_n),
      .data_i     (resp_i),
      .src_rdy_i  (resp_src_rdy_i),
      .dst_rdy_o  (resp_dst_rdy_o),
      .data_o     (resp_line),
      .src_rdy_o  (resp_src_rdy),
      .dst_rdy_i  (send_resp_line),
      .occupied_o (resp_level));

   // Only a full response burst clears the flag
   always_ff @(negedge gpif_clk) begin
      if (gpif_rst_i)
         gpif_empty_c_o <= 1'b1;
      else
         gpif_empty_c_o <= (resp_level < fifo_level_t'(RESP_READY_LEVEL));
   end

   assign gpif_data_o = gpif_ep_i ? resp_line[WORD_W-1:0] : pkt_line[WORD_W-1:0];

   // Markers at both ends of pkt_fifo, then handshake strobes
   assign debug_o = {16'd0,
                     cdc_line[EOP_BIT], cdc_line[SOP_BIT],
                     pkt_line[EOP_BIT], pkt_line[SOP_BIT],
                     pkt_count[3:0],
                     2'b00, pkt_src_rdy, resp_src_rdy,
                     send_data_line, send_resp_line,
                     cdc_src_rdy, pkt_dst_rdy};

endmodule

// File: tb/gpif_rd_props.sv
`timescale 1ns/10ps

module gpif_rd_props
   import gpif_pkg::*;
   (input logic        gpif_clk,
    input logic        gpif_rst_i,
    input logic        gpif_empty_d_o,
    input logic        gpif_empty_c_o,
    input logic        pkt_src_rdy,
    input logic        resp_src_rdy,
    input logic        sys_clk,
    input logic        sys_rst_i,
    input gpif_line_t  data_i,
    input logic        src_rdy_i,
    input logic        dst_rdy_o);

   // A falling flag needs a line waiting at the matching head
   assert property (@(negedge gpif_clk) disable iff (gpif_rst_i)
      $fell(gpif_empty_d_o) |-> pkt_src_rdy)
      else $error("data empty flag fell with pkt_fifo empty");

   assert property (@(negedge gpif_clk) disable iff (gpif_rst_i)
      $fell(gpif_empty_c_o) |-> resp_src_rdy)
      else $error("response empty flag fell with the response FIFO empty");

   // Stalled source keeps its line
   assert property (@(posedge sys_clk) disable iff (sys_rst_i)
      src_rdy_i && !dst_rdy_o |=> src_rdy_i && $stable(data_i))
      else $error("data line changed while the handshake was stalled");

endmodule

// File: tb/gpif_rd_tb.sv
`timescale 1ns/10ps

module gpif_rd_tb;
   import gpif_pkg::*;

   // Covers the 300 and 600 line tests with margin
   localparam int MAX_CYCLES = 3000;

   logic        gpif_clk;
   logic        gpif_rst;
   logic        gpif_rd;
   logic        gpif_ep;
   gpif_word_t  gpif_data;
   logic        empty_d;
   logic        empty_c;
   logic        sys_clk;
   logic        sys_rst;
   gpif_line_t  data;
   logic        src_rdy;
   logic        dst_rdy;
   gpif_line_t  resp;
   logic        resp_src_rdy;
   logic        resp_dst_rdy;
   debug_word_t debug;

   int         seed;
   int         cycles;
   int         word_errors;
   int         flag_errors;
   int         debug_errors;
   gpif_word_t exp_data[$];
   gpif_word_t exp_resp[$];

   gpif_rd dut_i (
      .gpif_clk       (gpif_clk),
      .gpif_rst_i     (gpif_rst),
      .gpif_data_o    (gpif_data),
      .gpif_rd_i      (gpif_rd),
      .gpif_ep_i      (gpif_ep),
      .gpif_empty_d_o (empty_d),
      .gpif_empty_c_o (empty_c),
      .sys_clk        (sys_clk),
      .sys_rst_i      (sys_rst),
      .data_i         (data),
      .src_rdy_i      (src_rdy),
      .dst_rdy_o      (dst_rdy),
      .resp_i         (resp),
      .resp_src_rdy_i (resp_src_rdy),
      .resp_dst_rdy_o (resp_dst_rdy),
      .debug_o        (debug));

   bind gpif_rd gpif_rd_props props_i (
      .gpif_clk       (gpif_clk),
      .gpif_rst_i     (gpif_rst_i),
      .gpif_empty_d_o (gpif_empty_d_o),
      .gpif_empty_c_o (gpif_empty_c_o),
      .pkt_src_rdy    (pkt_src_rdy),
      .resp_src_rdy   (resp_src_rdy),
      .sys_clk        (sys_clk),
      .sys_rst_i      (sys_rst_i),
      .data_i         (data_i),
      .src_rdy_i      (src_rdy_i),
      .dst_rdy_o      (dst_rdy_o));

   initial begin
      gpif_clk = 1'b0;
      forever #5 gpif_clk = ~gpif_clk;
   end

   initial begin
      sys_clk = 1'b0;
      #3;
      forever #5 sys_clk = ~sys_clk;
   end

   task automatic check_word(input gpif_word_t got, input gpif_word_t exp, input string what);
      if (got !== exp) begin
         $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
         word_errors++;
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
         flag_errors++;
      end
   endtask

   task automatic check_debug(input debug_word_t got, input debug_word_t exp,
                              input string what);
      if (got !== exp) begin
         $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
         debug_errors++;
      end
   endtask

   // Lines go out back to back, each held until dst_rdy_o takes it
   task automatic send_packet(input int n);
      gpif_line_t line;
      @(posedge sys_clk);
      for (int i = 0; i < n; i++) begin
         line = {i == n - 1, i == 0, gpif_word_t'($random(seed))};
         exp_data.push_back(line[WORD_W-1:0]);
         data <= line;
         src_rdy <= 1'b1;
         // Ready flag is stable between rising edges
         @(negedge sys_clk);
         while (!dst_rdy)
            @(negedge sys_clk);
         @(posedge sys_clk);
      end
      src_rdy <= 1'b0;
   endtask

   task automatic send_resp(input int n);
      gpif_line_t line;
      @(posedge sys_clk);
      for (int i = 0; i < n; i++) begin
         line = {2'b00, gpif_word_t'($random(seed))};
         exp_resp.push_back(line[WORD_W-1:0]);
         resp <= line;
         resp_src_rdy <= 1'b1;
         @(negedge sys_clk);
         while (!resp_dst_rdy)
            @(negedge sys_clk);
         @(posedge sys_clk);
      end
      resp_src_rdy <= 1'b0;
   endtask

   // n strobes in one burst; only the first pops are expected to advance the head
   task automatic gpif_read(input int n, input logic ep, input int pops);
      gpif_word_t exp;
      @(posedge gpif_clk);
      gpif_ep <= ep;
      for (int i = 0; i < n; i++) begin
         @(posedge gpif_clk);
         if (i >= pops)
            exp = ep ? exp_resp[0] : exp_data[0];
         else if (ep)
            exp = exp_resp.pop_front();
         else
            exp = exp_data.pop_front();
         check_word(gpif_data, exp, "burst word");
         gpif_rd <= 1'b1;
      end
      @(posedge gpif_clk);
      gpif_rd <= 1'b0;
   endtask

   task automatic test_reset_flags();
      repeat (20) begin
         @(posedge gpif_clk);
         check_flag(empty_d, 1'b1, "data empty after reset");
         check_flag(empty_c, 1'b1, "response empty after reset");
      end
   endtask

   task automatic test_single_packet();
      send_packet(10);
      while (empty_d)
         @(posedge gpif_clk);
      gpif_read(10, 1'b0, 10);
      @(posedge gpif_clk);
      check_flag(empty_d, 1'b1, "data empty after packet read");
   endtask

   task automatic test_resp_burst();
      send_resp(15);
      repeat (8) begin
         @(posedge gpif_clk);
         check_flag(empty_c, 1'b1, "response empty at 15 lines");
      end
      send_resp(1);
      while (empty_c)
         @(posedge gpif_clk);
      gpif_read(RESP_BURST_LINES, 1'b1, RESP_BURST_LINES);
      @(posedge gpif_clk);
      check_flag(empty_c, 1'b1, "response empty after burst");
   endtask

   task automatic test_burst_cap();
      send_packet(300);
      while (empty_d)
         @(posedge gpif_clk);
      gpif_read(300, 1'b0, DATA_BURST_LINES);
      gpif_read(300 - DATA_BURST_LINES, 1'b0, 300 - DATA_BURST_LINES);
   endtask

   // Six packets of 100 overfill both data buffers
   task automatic test_back_pressure();
      fork
         repeat (6)
            send_packet(100);
         begin
            @(negedge sys_clk);
            while (dst_rdy)
               @(negedge sys_clk);
            @(posedge gpif_clk);
            check_flag(empty_d, 1'b0, "data empty under back-pressure");
            repeat (6) begin
               while (empty_d)
                  @(posedge gpif_clk);
               gpif_read(100, 1'b0, 100);
            end
         end
      join
      @(posedge gpif_clk);
      check_flag(empty_d, 1'b1, "data empty after drain");
   endtask

   task automatic test_ep_switch();
      send_packet(4);
      send_resp(RESP_BURST_LINES);
      while (empty_d || empty_c)
         @(posedge gpif_clk);
      for (int k = 0; k < 6; k++) begin
         @(posedge gpif_clk);
         gpif_ep <= k[0];
         @(posedge gpif_clk);
         check_word(gpif_data, k[0] ? exp_resp[0] : exp_data[0], "head word, strobe low");
      end
      // Packet head at sop with one packet counted and both heads valid
      // Markers at the drained CDC head are stale
      check_debug(debug & 32'hffff_3fff, 32'h0000_1131, "debug word, strobe low");
      gpif_read(4, 1'b0, 4);
      gpif_read(RESP_BURST_LINES, 1'b1, RESP_BURST_LINES);
   endtask

   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge gpif_clk);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   initial begin
      seed = 13;
      word_errors = 0;
      flag_errors = 0;
      debug_errors = 0;
      gpif_rst = 1'b1;
      sys_rst = 1'b1;
      gpif_rd = 1'b0;
      gpif_ep = 1'b0;
      data = '0;
      src_rdy = 1'b0;
      resp = '0;
      resp_src_rdy = 1'b0;
      fork
         begin
            repeat (3) @(posedge gpif_clk);
            gpif_rst <= 1'b0;
         end
         begin
            repeat (3) @(posedge sys_clk);
            sys_rst <= 1'b0;
         end
      join
      test_reset_flags();
      test_single_packet();
      test_resp_burst();
      test_burst_cap();
      test_back_pressure();
      test_ep_switch();
      $display("Errors: %0d word, %0d flag, %0d debug",
               word_errors, flag_errors, debug_errors);
      if (word_errors + flag_errors + debug_errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// File: flist.f
verilog/gpif_pkg.sv
verilog/fifo_2clock.sv
verilog/fifo_sync.sv
verilog/gpif_rd.sv
tb/gpif_rd_props.sv
tb/gpif_rd_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
		--top-module gpif_rd_tb -f flist.f
	./obj_dir/Vgpif_rd_tb 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
